//--- sim.f
+incdir+include
source/backend_pkg.sv
source/backend_if.sv
source/apb_issue_port.sv
source/instr_buffer.sv
source/dispatch.sv
source/alu_lane.sv
source/commit_unit.sv
source/regfile.sv
source/backend_top.sv
tb/tb_backend_top.sv

//--- Bender.yml
package:
  name: backend_core

export_include_dirs:
  - include

sources:
  - files:
      - source/backend_pkg.sv
      - source/backend_if.sv
      - source/apb_issue_port.sv
      - source/instr_buffer.sv
      - source/dispatch.sv
      - source/alu_lane.sv
      - source/commit_unit.sv
      - source/regfile.sv
      - source/backend_top.sv
  - target: test
    files:
      - tb/tb_backend_top.sv

//--- tb/tb_backend_top.sv
`include "core_config.svh"

module tb_backend_top;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD  = 100;
    localparam int TOTAL_INSTR = 92;   // Pushes summed over all tests
    localparam int K_ADD   = 0;
    localparam int K_SUB   = 1;
    localparam int K_AND   = 2;
    localparam int K_OR    = 3;
    localparam int K_XOR   = 4;
    localparam int K_SLT   = 5;
    localparam int K_ADDI  = 6;
    localparam int K_UNDEF = 7;

    logic        clk = 1'b0;
    logic        reset_i;
    logic        psel_i;
    logic        penable_i;
    logic        pwrite_i;
    logic [11:0] paddr_i;
    logic [31:0] pwdata_i;
    logic [31:0] prdata_o;
    logic        pready_o;
    logic        pslverr_o;
    logic        commit0_valid_o;
    logic [4:0]  commit0_wnum_o;
    logic [31:0] commit0_wdata_o;
    logic        commit1_valid_o;
    logic [4:0]  commit1_wnum_o;
    logic [31:0] commit1_wdata_o;

    logic [31:0] lfsr_state = 32'he9a1b9ed;
    logic [31:0] model_regs [32];
    logic [4:0]  exp_wnum [$];    // Expected commits in program order
    logic [31:0] exp_wdata [$];
    int          errors;
    int          n_tests;
    int          n_pushed;
    int          bp_waits;
    int          dual_commits;

    backend_top u_backend_top (.*);

    initial begin
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_state[0] ? (lfsr_state >> 1) ^ 32'ha3000000 : lfsr_state >> 1;
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic logic [16:0] opcode_of(input int kind);
        case (kind)
            K_ADD:   return `OP_ADD_W;
            K_SUB:   return `OP_SUB_W;
            K_AND:   return `OP_AND;
            K_OR:    return `OP_OR;
            K_XOR:   return `OP_XOR;
            K_SLT:   return `OP_SLT;
            default: return 17'h00001;   // Outside the subset
        endcase
    endfunction

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            $display("** Error: %s expected %h, got %h", name, exp, got);
            errors++;
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        assert (cond) else begin
            $display("Error: %s", what);
            errors++;
        end
    endtask

    // Starts and ends on a falling edge
    task automatic apb_xfer(input logic wr, input logic [11:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err, output int waits);
        psel_i    = 1'b1;
        penable_i = 1'b0;
        pwrite_i  = wr;
        paddr_i   = addr;
        pwdata_i  = wdata;
        waits     = 0;
        @(negedge clk);
        penable_i = 1'b1;
        #(CLK_PERIOD / 4);
        while (!pready_o && waits < 200) begin
            waits++;
            @(negedge clk);
            #(CLK_PERIOD / 4);
        end
        check_true(pready_o, $sformatf("APB transfer to address %h never completed", addr));
        rdata = prdata_o;
        err   = pslverr_o;
        @(negedge clk);
        psel_i    = 1'b0;
        penable_i = 1'b0;
    endtask

    task automatic apb_write(input logic [11:0] addr, input logic [31:0] data, output logic err);
        logic [31:0] unused;
        int          waits;
        apb_xfer(1'b1, addr, data, unused, err, waits);
        bp_waits += waits;
    endtask

    task automatic apb_read(input logic [11:0] addr, output logic [31:0] data, output logic err);
        int waits;
        apb_xfer(1'b0, addr, 32'h0, data, err, waits);
    endtask

    // Model update and expected commit, then the push itself
    task automatic issue_instr(input int kind, input logic [4:0] rd, input logic [4:0] rj,
                               input logic [4:0] rk, input logic [11:0] imm);
        logic [31:0] word;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] val;
        logic        err;
        a = model_regs[rj];
        b = (kind == K_ADDI) ? {{20{imm[11]}}, imm} : model_regs[rk];
        case (kind)
            K_ADD, K_ADDI: val = a + b;
            K_SUB:         val = a - b;
            K_AND:         val = a & b;
            K_OR:          val = a | b;
            K_XOR:         val = a ^ b;
            K_SLT:         val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            default:       val = 32'd0;
        endcase
        if (kind == K_ADDI) begin
            word = {`OP_ADDI_W, imm, rj, rd};
        end else begin
            word = {opcode_of(kind), rk, rj, rd};
        end
        if (kind != K_UNDEF && rd != 5'd0) begin
            model_regs[rd] = val;
            exp_wnum.push_back(rd);
            exp_wdata.push_back(val);
        end else begin
            exp_wnum.push_back(5'd0);   // No-op and r0 writes report zero
            exp_wdata.push_back(32'd0);
        end
        apb_write(`APB_INSTR, word, err);
        check_val("pslverr_o on push", {31'd0, err}, 32'd0);
        n_pushed++;
    endtask

    task automatic wait_retire();
        logic [31:0] st;
        logic        err;
        int          polls;
        polls = 0;
        apb_read(`APB_STATUS, st, err);
        while (st != n_pushed && polls < 100) begin
            polls++;
            apb_read(`APB_STATUS, st, err);
        end
        check_val("prdata_o (APB_STATUS)", st, n_pushed);
    endtask

    task automatic check_all_regs();
        logic [31:0] data;
        logic        err;
        for (int r = 0; r < 32; r++) begin
            apb_read(`APB_REG_BASE + 12'(4 * r), data, err);
            check_val($sformatf("prdata_o (r%0d)", r), data, model_regs[r]);
            check_val("pslverr_o on register read", {31'd0, err}, 32'd0);
        end
    endtask

    task automatic end_test(input string name, input int e0);
        n_tests++;
        $display("%-16s %s, %0d errors", name, (errors == e0) ? "ok" : "failed", errors - e0);
    endtask

    task automatic compare_commit(input int port, input logic [4:0] wnum, input logic [31:0] wdata);
        if (exp_wnum.size() == 0) begin
            check_true(1'b0, $sformatf("commit on port %0d with no instruction pending", port));
        end else begin
            check_val($sformatf("commit%0d_wnum_o", port), wnum, exp_wnum.pop_front());
            check_val($sformatf("commit%0d_wdata_o", port), wdata, exp_wdata.pop_front());
        end
    endtask

    // Port 0 is checked first since lane 0 holds the older instruction
    always @(negedge clk) begin
        if (!reset_i) begin
            check_true(!(commit1_valid_o && !commit0_valid_o), "lane 1 committed without lane 0");
            if (commit0_valid_o) begin
                compare_commit(0, commit0_wnum_o, commit0_wdata_o);
            end
            if (commit1_valid_o) begin
                compare_commit(1, commit1_wnum_o, commit1_wdata_o);
            end
            if (commit0_valid_o && commit1_valid_o) begin
                dual_commits++;
            end
        end
    end

    task automatic reset_values();
        int          e0;
        logic [31:0] d;
        logic        err;
        e0 = errors;
        check_val("pready_o", {31'd0, pready_o}, 32'd0);
        check_val("pslverr_o", {31'd0, pslverr_o}, 32'd0);
        check_true(!commit0_valid_o && !commit1_valid_o, "commit valid high after reset");
        check_all_regs();
        apb_read(`APB_STATUS, d, err);
        check_val("prdata_o (APB_STATUS)", d, 32'd0);
        end_test("reset_values", e0);
    endtask

    task automatic alu_ops();
        int e0;
        e0 = errors;
        for (int round = 0; round < 2; round++) begin
            for (int r = 1; r <= 8; r++) begin
                issue_instr(K_ADDI, 5'(r), 5'd0, 5'd0, 12'(rand_bits(12)));
            end
            for (int k = K_ADD; k <= K_UNDEF; k++) begin
                issue_instr(k, 5'(rand_bits(5)), 5'(1 + rand_bits(3)), 5'(1 + rand_bits(3)),
                            12'(rand_bits(12)));
            end
        end
        wait_retire();
        check_all_regs();
        end_test("alu_ops", e0);
    endtask

    task automatic dependent_chain();
        int e0;
        e0 = errors;
        issue_instr(K_ADDI, 5'd10, 5'd0, 5'd0, 12'h005);
        issue_instr(K_ADD, 5'd11, 5'd10, 5'd10, 12'h0);
        issue_instr(K_ADDI, 5'd11, 5'd11, 5'd0, 12'hffd);   // -3
        issue_instr(K_SUB, 5'd12, 5'd11, 5'd10, 12'h0);
        issue_instr(K_SLT, 5'd13, 5'd12, 5'd11, 12'h0);
        issue_instr(K_XOR, 5'd10, 5'd13, 5'd12, 12'h0);
        issue_instr(K_OR, 5'd14, 5'd10, 5'd11, 12'h0);
        issue_instr(K_AND, 5'd15, 5'd14, 5'd12, 12'h0);
        wait_retire();
        check_all_regs();
        end_test("dependent_chain", e0);
    endtask

    task automatic commit_order();
        int e0;
        int d0;
        e0 = errors;
        d0 = dual_commits;
        // Stalling chain lets the independent ones queue up and pair
        for (int i = 0; i < 12; i++) begin
            issue_instr(K_ADDI, 5'd20, 5'd20, 5'd0, 12'h001);
        end
        for (int i = 0; i < 8; i++) begin
            if (i == 3) begin
                issue_instr(K_ADDI, 5'd0, 5'd0, 5'd0, 12'h7ff);
            end else if (i == 6) begin
                issue_instr(K_UNDEF, 5'd9, 5'd1, 5'd2, 12'h0);
            end else begin
                issue_instr(K_ADDI, 5'(22 + i), 5'd0, 5'd0, 12'(rand_bits(12)));
            end
        end
        wait_retire();
        check_all_regs();
        check_true(dual_commits > d0, "no cycle committed on both lanes");
        end_test("commit_order", e0);
    endtask

    task automatic back_pressure();
        int e0;
        int w0;
        int kind;
        e0 = errors;
        w0 = bp_waits;
        for (int i = 0; i < 32; i++) begin
            kind = (i % 3 == 0) ? K_ADDI : ((i % 3 == 1) ? K_ADD : K_XOR);
            issue_instr(kind, 5'd25, 5'd25, 5'd24, 12'(rand_bits(12)));
        end
        check_true(bp_waits > w0, "instruction buffer never filled");
        wait_retire();
        check_all_regs();
        end_test("back_pressure", e0);
    endtask

    task automatic bus_errors();
        int          e0;
        logic [31:0] d;
        logic        err;
        e0 = errors;
        apb_read(12'h008, d, err);
        check_val("pslverr_o (unmapped read)", {31'd0, err}, 32'd1);
        apb_write(12'h200, 32'h0002_8c21, err);
        check_val("pslverr_o (unmapped write)", {31'd0, err}, 32'd1);
        apb_write(`APB_STATUS, 32'h0000_1234, err);
        check_val("pslverr_o (write to APB_STATUS)", {31'd0, err}, 32'd1);
        apb_read(`APB_INSTR, d, err);
        check_val("pslverr_o (read of APB_INSTR)", {31'd0, err}, 32'd1);
        apb_write(`APB_REG_BASE + 12'h004, 32'hffff_ffff, err);
        check_val("pslverr_o (write to register)", {31'd0, err}, 32'd1);
        repeat (6) @(negedge clk);
        apb_read(`APB_STATUS, d, err);
        check_val("prdata_o (APB_STATUS)", d, n_pushed);
        check_all_regs();
        end_test("bus_errors", e0);
    endtask

    initial begin
        reset_i   = 1'b1;
        psel_i    = 1'b0;
        penable_i = 1'b0;
        pwrite_i  = 1'b0;
        paddr_i   = '0;
        pwdata_i  = '0;
        for (int r = 0; r < 32; r++) begin
            model_regs[r] = '0;
        end
        repeat (3) @(negedge clk);
        reset_i = 1'b0;
        reset_values();
        alu_ops();
        dependent_chain();
        commit_order();
        back_pressure();
        bus_errors();
        repeat (4) @(negedge clk);
        check_true(exp_wnum.size() == 0, "instructions pushed but never committed");
        $display("Tests run: %0d, errors: %0d", n_tests, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    initial begin
        repeat (TOTAL_INSTR * 20 + 2000) @(posedge clk);
        $display("Watchdog expired before the tests finished");
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

//--- source/backend_top.sv
`include "core_config.svh"

module backend_top (
    input  logic               clk,
    input  logic               reset_i,
    input  logic               psel_i,
    input  logic               penable_i,
    input  logic               pwrite_i,
    input  logic [11:0]        paddr_i,
    input  logic [`XLEN-1:0]   pwdata_i,
    output logic [`XLEN-1:0]   prdata_o,
    output logic               pready_o,
    output logic               pslverr_o,
    output logic               commit0_valid_o,
    output logic [`REG_AW-1:0] commit0_wnum_o,
    output logic [`XLEN-1:0]   commit0_wdata_o,
    output logic               commit1_valid_o,
    output logic [`REG_AW-1:0] commit1_wnum_o,
    output logic [`XLEN-1:0]   commit1_wdata_o
);
    issue_if  iss [`NUM_LANES] ();
    result_if res [`NUM_LANES] ();

    logic                               ib_push;
    logic                               ib_full;
    backend_pkg::instr_u                ib_push_data;
    backend_pkg::instr_u                ib_head0;
    backend_pkg::instr_u                ib_head1;
    logic [`IB_CW-1:0]                  ib_count;
    logic [1:0]                         pop_count;
    logic [3:0][`REG_AW-1:0]            disp_raddr;
    logic [`REG_AW-1:0]                 apb_raddr;
    logic [4:0][`XLEN-1:0]              rf_rdata;
    logic [`NUM_LANES-1:0]              rf_we;
    logic [`NUM_LANES-1:0][`REG_AW-1:0] rf_waddr;
    logic [`NUM_LANES-1:0][`XLEN-1:0]   rf_wdata;
    logic [`XLEN-1:0]                   retired;

    apb_issue_port u_apb_issue_port (
        .clk         (clk),
        .reset_i     (reset_i),
        .psel_i      (psel_i),
        .penable_i   (penable_i),
        .pwrite_i    (pwrite_i),
        .paddr_i     (paddr_i),
        .pwdata_i    (pwdata_i),
        .full_i      (ib_full),
        .rf_rdata_i  (rf_rdata[4]),
        .retired_i   (retired),
        .prdata_o    (prdata_o),
        .pready_o    (pready_o),
        .pslverr_o   (pslverr_o),
        .push_o      (ib_push),
        .push_data_o (ib_push_data),
        .rf_raddr_o  (apb_raddr)
    );

    instr_buffer u_instr_buffer (
        .clk         (clk),
        .reset_i     (reset_i),
        .push_i      (ib_push),
        .push_data_i (ib_push_data),
        .pop_count_i (pop_count),
        .full_o      (ib_full),
        .head0_o     (ib_head0),
        .head1_o     (ib_head1),
        .count_o     (ib_count)
    );

    dispatch u_dispatch (
        .clk         (clk),
        .reset_i     (reset_i),
        .head0_i     (ib_head0),
        .head1_i     (ib_head1),
        .count_i     (ib_count),
        .pop_count_o (pop_count),
        .rf_raddr_o  (disp_raddr),
        .rf_rdata_i  (rf_rdata[3:0]),
        .iss_o       (iss),
        .iss_mon_i   (iss),
        .res_i       (res)
    );

    for (genvar g = 0; g < `NUM_LANES; g++) begin : g_lane
        alu_lane u_alu_lane (
            .clk     (clk),
            .reset_i (reset_i),
            .iss_i   (iss[g]),
            .res_o   (res[g])
        );
    end

    commit_unit u_commit_unit (
        .clk             (clk),
        .reset_i         (reset_i),
        .res_i           (res),
        .rf_we_o         (rf_we),
        .rf_waddr_o      (rf_waddr),
        .rf_wdata_o      (rf_wdata),
        .commit0_valid_o (commit0_valid_o),
        .commit0_wnum_o  (commit0_wnum_o),
        .commit0_wdata_o (commit0_wdata_o),
        .commit1_valid_o (commit1_valid_o),
        .commit1_wnum_o  (commit1_wnum_o),
        .commit1_wdata_o (commit1_wdata_o),
        .retired_o       (retired)
    );

    // Read port 4 belongs to the APB side
    regfile #(
        .READ_PORTS (5)
    ) u_regfile (
        .clk     (clk),
        .reset_i (reset_i),
        .we_i    (rf_we),
        .waddr_i (rf_waddr),
        .wdata_i (rf_wdata),
        .raddr_i ({apb_raddr, disp_raddr}),
        .rdata_o (rf_rdata)
    );

endmodule

//--- source/regfile.sv
`include "core_config.svh"

module regfile #(
    parameter int READ_PORTS = 5
) (
    input  logic                                clk,
    input  logic                                reset_i,
    input  logic [1:0]                          we_i,
    input  logic [1:0][`REG_AW-1:0]             waddr_i,
    input  logic [1:0][`XLEN-1:0]               wdata_i,
    input  logic [READ_PORTS-1:0][`REG_AW-1:0]  raddr_i,
    output logic [READ_PORTS-1:0][`XLEN-1:0]    rdata_o
);
    logic [`XLEN-1:0] regs [`REG_COUNT];

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int r = 0; r < `REG_COUNT; r++) begin
                regs[r] <= '0;
            end
        end else begin
            for (int p = 0; p < 2; p++) begin   // Port 1 last, so it wins
                if (we_i[p]) begin
                    regs[waddr_i[p]] <= wdata_i[p];
                end
            end
        end
    end

    always_comb begin
        for (int r = 0; r < READ_PORTS; r++) begin
            rdata_o[r] = (raddr_i[r] == '0) ? '0 : regs[raddr_i[r]];
        end
    end

endmodule

//--- source/commit_unit.sv
`include "core_config.svh"

module commit_unit (
    input  logic                                clk,
    input  logic                                reset_i,
    result_if.sink                              res_i [`NUM_LANES],
    output logic [`NUM_LANES-1:0]               rf_we_o,
    output logic [`NUM_LANES-1:0][`REG_AW-1:0]  rf_waddr_o,
    output logic [`NUM_LANES-1:0][`XLEN-1:0]    rf_wdata_o,
    output logic                                commit0_valid_o,
    output logic [`REG_AW-1:0]                  commit0_wnum_o,
    output logic [`XLEN-1:0]                    commit0_wdata_o,
    output logic                                commit1_valid_o,
    output logic [`REG_AW-1:0]                  commit1_wnum_o,
    output logic [`XLEN-1:0]                    commit1_wdata_o,
    output logic [`XLEN-1:0]                    retired_o
);
    logic [`NUM_LANES-1:0]              vld;
    logic [`NUM_LANES-1:0]              cm_valid;
    logic [`NUM_LANES-1:0][`REG_AW-1:0] cm_wnum;
    logic [`NUM_LANES-1:0][`XLEN-1:0]   cm_wdata;
    logic [`XLEN-1:0]                   n_retire;

    for (genvar g = 0; g < `NUM_LANES; g++) begin : g_lane
        logic               valid_q;
        logic [`REG_AW-1:0] wnum_q;
        logic [`XLEN-1:0]   wdata_q;

        assign vld[g]        = res_i[g].valid;
        assign rf_we_o[g]    = res_i[g].valid && res_i[g].we && res_i[g].rd != '0;
        assign rf_waddr_o[g] = res_i[g].rd;
        assign rf_wdata_o[g] = res_i[g].wdata;

        // No-ops and r0 writes show up as wnum 0, wdata 0
        always_ff @(posedge clk) begin
            if (reset_i) begin
                valid_q <= 1'b0;
                wnum_q  <= '0;
                wdata_q <= '0;
            end else begin
                valid_q <= vld[g];
                wnum_q  <= rf_we_o[g] ? res_i[g].rd : '0;
                wdata_q <= rf_we_o[g] ? res_i[g].wdata : '0;
            end
        end

        assign cm_valid[g] = valid_q;
        assign cm_wnum[g]  = wnum_q;
        assign cm_wdata[g] = wdata_q;
    end

    always_comb begin
        n_retire = '0;
        for (int l = 0; l < `NUM_LANES; l++) begin
            n_retire = n_retire + `XLEN'(vld[l]);
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            retired_o <= '0;
        end else begin
            retired_o <= retired_o + n_retire;
        end
    end

    assign commit0_valid_o = cm_valid[0];
    assign commit0_wnum_o  = cm_wnum[0];
    assign commit0_wdata_o = cm_wdata[0];
    assign commit1_valid_o = cm_valid[1];
    assign commit1_wnum_o  = cm_wnum[1];
    assign commit1_wdata_o = cm_wdata[1];

endmodule

//--- source/alu_lane.sv
`include "core_config.svh"

module alu_lane (
    input  logic     clk,
    input  logic     reset_i,
    issue_if.sink    iss_i,
    result_if.source res_o
);
    logic [`XLEN-1:0] result;

    always_comb begin
        case (iss_i.op)
            backend_pkg::ALU_ADD: result = iss_i.opa + iss_i.opb;
            backend_pkg::ALU_SUB: result = iss_i.opa - iss_i.opb;
            backend_pkg::ALU_AND: result = iss_i.opa & iss_i.opb;
            backend_pkg::ALU_OR:  result = iss_i.opa | iss_i.opb;
            backend_pkg::ALU_XOR: result = iss_i.opa ^ iss_i.opb;
            backend_pkg::ALU_SLT: result = `XLEN'($signed(iss_i.opa) < $signed(iss_i.opb));
            default:              result = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            res_o.valid <= 1'b0;
            res_o.we    <= 1'b0;
        end else begin
            res_o.valid <= iss_i.valid;
            res_o.we    <= iss_i.valid && iss_i.we && iss_i.op != backend_pkg::ALU_NOP;
        end
        res_o.rd    <= iss_i.rd;
        res_o.wdata <= result;
    end

endmodule

//--- source/dispatch.sv
`include "core_config.svh"

module dispatch (
    input  logic                        clk,
    input  logic                        reset_i,
    input  backend_pkg::instr_u         head0_i,
    input  backend_pkg::instr_u         head1_i,
    input  logic [`IB_CW-1:0]           count_i,
    output logic [1:0]                  pop_count_o,
    output logic [3:0][`REG_AW-1:0]     rf_raddr_o,
    input  logic [3:0][`XLEN-1:0]       rf_rdata_i,
    issue_if.source                     iss_o [`NUM_LANES],
    issue_if.monitor                    iss_mon_i [`NUM_LANES],
    result_if.monitor                   res_i [`NUM_LANES]
);
    backend_pkg::instr_u      hd [`NUM_LANES];
    backend_pkg::alu_op_e     op [`NUM_LANES];
    backend_pkg::issue_slot_t slot_d [`NUM_LANES];
    backend_pkg::issue_slot_t slot_q [`NUM_LANES];
    logic [`NUM_LANES-1:0]    is_imm;
    logic [`NUM_LANES-1:0]    we;
    logic [`NUM_LANES-1:0]    use_rk;
    logic [`NUM_LANES-1:0]    hazard;
    logic [`NUM_LANES-1:0]    issue;
    logic                     raw_pair;
    logic                     waw_pair;
    logic [`REG_COUNT-1:0]    pend;
    logic [`NUM_LANES-1:0][`REG_COUNT-1:0] pend_lane;

    assign hd[0] = head0_i;
    assign hd[1] = head1_i;

    for (genvar g = 0; g < `NUM_LANES; g++) begin : g_lane
        assign iss_o[g].valid = slot_q[g].valid;
        assign iss_o[g].op    = slot_q[g].op;
        assign iss_o[g].rd    = slot_q[g].rd;
        assign iss_o[g].we    = slot_q[g].we;
        assign iss_o[g].opa   = slot_q[g].opa;
        assign iss_o[g].opb   = slot_q[g].opb;

        // Destinations still in flight in this lane
        assign pend_lane[g] =
            ((iss_mon_i[g].valid && iss_mon_i[g].we) ? `REG_COUNT'(1) << iss_mon_i[g].rd : '0) |
            ((res_i[g].valid && res_i[g].we) ? `REG_COUNT'(1) << res_i[g].rd : '0);
    end

    always_comb begin
        pend = '0;
        for (int l = 0; l < `NUM_LANES; l++) begin
            pend = pend | pend_lane[l];
        end
        pend[0] = 1'b0;   // r0 never blocks
    end

    always_comb begin
        for (int i = 0; i < `NUM_LANES; i++) begin
            is_imm[i] = hd[i].ri12.opcode == `OP_ADDI_W;
            case (hd[i].r3.opcode)
                `OP_ADD_W: op[i] = backend_pkg::ALU_ADD;
                `OP_SUB_W: op[i] = backend_pkg::ALU_SUB;
                `OP_AND:   op[i] = backend_pkg::ALU_AND;
                `OP_OR:    op[i] = backend_pkg::ALU_OR;
                `OP_XOR:   op[i] = backend_pkg::ALU_XOR;
                `OP_SLT:   op[i] = backend_pkg::ALU_SLT;
                default:   op[i] = is_imm[i] ? backend_pkg::ALU_ADD : backend_pkg::ALU_NOP;
            endcase
            we[i]     = op[i] != backend_pkg::ALU_NOP;
            use_rk[i] = we[i] && !is_imm[i];
            hazard[i] = (we[i] && pend[hd[i].r3.rj]) || (use_rk[i] && pend[hd[i].r3.rk]);

            rf_raddr_o[2*i]   = hd[i].r3.rj;
            rf_raddr_o[2*i+1] = hd[i].r3.rk;

            slot_d[i].op  = op[i];
            slot_d[i].rd  = hd[i].r3.rd;
            slot_d[i].we  = we[i];
            slot_d[i].opa = rf_rdata_i[2*i];
            slot_d[i].opb = is_imm[i] ?
                {{(`XLEN-12){hd[i].ri12.si12[11]}}, hd[i].ri12.si12} : rf_rdata_i[2*i+1];
        end

        // Pairing rules for the younger instruction
        raw_pair = we[0] && hd[0].r3.rd != '0 &&
                   ((we[1] && hd[1].r3.rj == hd[0].r3.rd) ||
                    (use_rk[1] && hd[1].r3.rk == hd[0].r3.rd));
        waw_pair = we[0] && we[1] && hd[0].r3.rd == hd[1].r3.rd;

        issue[0] = count_i != '0 && !hazard[0];
        issue[1] = issue[0] && count_i > `IB_CW'(1) && !hazard[1] && !raw_pair && !waw_pair;

        slot_d[0].valid = issue[0];
        slot_d[1].valid = issue[1];
        pop_count_o = issue[1] ? 2'd2 : {1'b0, issue[0]};
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < `NUM_LANES; i++) begin
            slot_q[i] <= slot_d[i];
            if (reset_i) begin
                slot_q[i].valid <= 1'b0;
            end
        end
    end

endmodule

//--- source/instr_buffer.sv
`include "core_config.svh"

module instr_buffer (
    input  logic                clk,
    input  logic                reset_i,
    input  logic                push_i,
    input  backend_pkg::instr_u push_data_i,
    input  logic [1:0]          pop_count_i,
    output logic                full_o,
    output backend_pkg::instr_u head0_o,
    output backend_pkg::instr_u head1_o,
    output logic [`IB_CW-1:0]   count_o
);
    localparam int AW = $clog2(`IB_DEPTH);

    backend_pkg::instr_u mem [`IB_DEPTH];
    logic [AW-1:0]       wr_ptr;
    logic [AW-1:0]       rd_ptr;
    logic                push_ok;

    assign full_o  = count_o == `IB_CW'(`IB_DEPTH);
    assign push_ok = push_i && !full_o;

    always_ff @(posedge clk) begin
        if (push_ok) begin
            mem[wr_ptr] <= push_data_i;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count_o <= '0;
        end else begin
            wr_ptr  <= wr_ptr + AW'(push_ok);
            rd_ptr  <= rd_ptr + AW'(pop_count_i);
            count_o <= count_o + `IB_CW'(push_ok) - `IB_CW'(pop_count_i);
        end
    end

    // Pointer wraps on its own width
    assign head0_o = mem[rd_ptr];
    assign head1_o = mem[rd_ptr + AW'(1)];

endmodule

//--- source/apb_issue_port.sv
`include "core_config.svh"

module apb_issue_port (
    input  logic                clk,
    input  logic                reset_i,
    input  logic                psel_i,
    input  logic                penable_i,
    input  logic                pwrite_i,
    input  logic [11:0]         paddr_i,
    input  logic [`XLEN-1:0]    pwdata_i,
    input  logic                full_i,
    input  logic [`XLEN-1:0]    rf_rdata_i,
    input  logic [`XLEN-1:0]    retired_i,
    output logic [`XLEN-1:0]    prdata_o,
    output logic                pready_o,
    output logic                pslverr_o,
    output logic                push_o,
    output backend_pkg::instr_u push_data_o,
    output logic [`REG_AW-1:0]  rf_raddr_o
);
    logic        setup_q;
    logic        access;
    logic        is_instr;
    logic        is_status;
    logic        is_reg;
    logic        mapped;
    logic [11:0] reg_off;

    // Set after a setup phase, held while the access phase waits
    always_ff @(posedge clk) begin
        if (reset_i) begin
            setup_q <= 1'b0;
        end else begin
            setup_q <= psel_i && (!penable_i || (setup_q && !pready_o));
        end
    end

    assign access    = psel_i && penable_i && setup_q;
    assign reg_off   = paddr_i - `APB_REG_BASE;
    assign is_instr  = paddr_i == `APB_INSTR;
    assign is_status = paddr_i == `APB_STATUS;
    assign is_reg    = reg_off < 12'(4 * `REG_COUNT) && reg_off[1:0] == 2'b00;
    assign mapped    = pwrite_i ? is_instr : (is_status || is_reg);

    // Only an instruction push waits, and only on a full buffer
    assign pready_o  = access && !(is_instr && pwrite_i && full_i);
    assign pslverr_o = pready_o && !mapped;
    assign push_o    = pready_o && is_instr && pwrite_i;

    assign push_data_o = pwdata_i;
    assign rf_raddr_o  = reg_off[`REG_AW+1:2];

    always_comb begin
        prdata_o = '0;
        if (is_status) begin
            prdata_o = retired_i;
        end else if (is_reg) begin
            prdata_o = rf_rdata_i;
        end
    end

endmodule

//--- source/backend_if.sv
`include "core_config.svh"

interface issue_if;
    logic                 valid;
    backend_pkg::alu_op_e op;
    logic [`REG_AW-1:0]   rd;
    logic                 we;
    logic [`XLEN-1:0]     opa;
    logic [`XLEN-1:0]     opb;

    modport source (output valid, op, rd, we, opa, opb);
    modport sink (input valid, op, rd, we, opa, opb);
    modport monitor (input valid, rd, we);   // Hazard tracking only
endinterface

interface result_if;
    logic               valid;
    logic               we;
    logic [`REG_AW-1:0] rd;
    logic [`XLEN-1:0]   wdata;

    modport source (output valid, we, rd, wdata);
    modport sink (input valid, we, rd, wdata);
    modport monitor (input valid, we, rd);
endinterface

//--- source/backend_pkg.sv
`include "core_config.svh"

package backend_pkg;

    // 3R view with opcode in bits 31:15
    typedef struct packed {
        logic [16:0]        opcode;
        logic [`REG_AW-1:0] rk;
        logic [`REG_AW-1:0] rj;
        logic [`REG_AW-1:0] rd;
    } r3_t;

    // 2RI12 view with opcode in bits 31:22
    typedef struct packed {
        logic [9:0]         opcode;
        logic [11:0]        si12;
        logic [`REG_AW-1:0] rj;
        logic [`REG_AW-1:0] rd;
    } ri12_t;

    typedef union packed {
        r3_t   r3;
        ri12_t ri12;
    } instr_u;

    typedef enum logic [2:0] {
        ALU_NOP,
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT
    } alu_op_e;

    typedef struct packed {
        logic               valid;
        alu_op_e            op;
        logic [`REG_AW-1:0] rd;
        logic               we;
        logic [`XLEN-1:0]   opa;
        logic [`XLEN-1:0]   opb;   // Register value or extended immediate
    } issue_slot_t;

endpackage

//--- include/core_config.svh
`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

`define NUM_LANES    2
`define XLEN         32
`define REG_COUNT    32
`define REG_AW       5
`define IB_DEPTH     8
`define IB_CW        4

// LoongArch 3R opcodes in bits 31:15
`define OP_ADD_W     17'h00020
`define OP_SUB_W     17'h00022
`define OP_SLT       17'h00024
`define OP_AND       17'h00029
`define OP_OR        17'h0002a
`define OP_XOR       17'h0002b
`define OP_ADDI_W    10'h00a   // 2RI12 opcode in bits 31:22

`define APB_INSTR    12'h000
`define APB_STATUS   12'h004
`define APB_REG_BASE 12'h100

`endif
